// ==== Bender.yml ====
package:
  name: cuckoo_counter

sources:
  - files:
      - source/cuckoo_pkg.sv
      - source/stage_if.sv
      - source/bucket_ram.sv
      - source/bucket_probe.sv
      - source/cmd_admit.sv
      - source/primary_stage.sv
      - source/alternate_stage.sv
      - source/cuckoo_counter_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_cuckoo.sv

// ==== compile.f ====
+incdir+test
source/cuckoo_pkg.sv
source/stage_if.sv
source/bucket_ram.sv
source/bucket_probe.sv
source/cmd_admit.sv
source/primary_stage.sv
source/alternate_stage.sv
source/cuckoo_counter_top.sv
test/tb_cuckoo.sv

// ==== source/alternate_stage.sv ====
/*
 * alternate bucket stage
 * probes and updates the alternate bucket, forms and registers the result
 */
`timescale 1ns/100ps

module alternate_stage import cuckoo_pkg::*; #(
    parameter int TABLE_ADDR_LEN = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    stage_if.dst                      in,
    input  bucket_t                   rd_data,
    output logic                      we,
    output logic [TABLE_ADDR_LEN-1:0] wr_addr,
    output bucket_t                   wr_data,
    output logic                      valid_out,
    output cmd_t                      cmd_out,
    output logic                      success_out,
    output count_t                    counter_size
);

    h1_t     in_alt_h1;
    fp_t     in_fp;
    logic    in_insert;
    logic    hit;
    count_t  hit_count;
    logic    has_empty;
    bucket_t bumped;
    bucket_t placed;
    logic    s_valid;
    cmd_t    s_cmd;
    logic    s_resolved;
    logic    s_success;
    count_t  s_count;
    logic    s_hit;
    count_t  s_hit_count;
    logic    s_has_empty;
    logic    s_insert;
    logic    fin_success;
    count_t  fin_count;

    assign in_alt_h1 = cmd_alt_h1(in.cmd);
    assign in_fp     = cmd_fp(in.cmd);
    assign in_insert = (cmd_op(in.cmd) == op_insert);

    bucket_probe u_probe (
        .bucket    (rd_data),
        .fp        (in_fp),
        .hit       (hit),
        .hit_count (hit_count),
        .has_empty (has_empty),
        .bumped    (bumped),
        .placed    (placed)
    );

    // a full bucket without a match leaves the table untouched
    assign we      = in.valid && !in.resolved && in_insert && (hit || has_empty);
    assign wr_addr = in_alt_h1[TABLE_ADDR_LEN-1:0];
    assign wr_data = hit ? bumped : placed;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_valid   <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            s_valid   <= in.valid;
            valid_out <= s_valid;
        end
    end

    always_ff @(posedge clk) begin
        s_cmd       <= in.cmd;
        s_resolved  <= in.resolved;
        s_success   <= in.success;
        s_count     <= in.count;
        s_hit       <= hit;
        s_hit_count <= hit_count;
        s_has_empty <= has_empty;
    end

    assign s_insert = (cmd_op(s_cmd) == op_insert);

    always_comb begin
        if (s_resolved) begin  // settled in the primary table
            fin_success = s_success;
            fin_count   = s_count;
        end else if (s_hit) begin
            fin_success = 1'b1;
            fin_count   = s_insert ? s_hit_count + count_t'(1) : s_hit_count;
        end else if (s_insert && s_has_empty) begin
            fin_success = 1'b1;
            fin_count   = count_t'(1);
        end else begin
            fin_success = 1'b0;
            fin_count   = '0;
        end
    end

    always_ff @(posedge clk) begin
        cmd_out      <= s_cmd;
        success_out  <= fin_success;
        counter_size <= fin_count;
    end

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(valid_out));

endmodule

// ==== source/bucket_probe.sv ====
/*
 * fingerprint search in one bucket
 * reports the matching count and forms the bumped and placed buckets
 */
`timescale 1ns/100ps

module bucket_probe import cuckoo_pkg::*; (
    input  bucket_t bucket,
    input  fp_t     fp,
    output logic    hit,
    output count_t  hit_count,
    output logic    has_empty,
    output bucket_t bumped,
    output bucket_t placed
);

    fp_t    slot_fp  [SLOTS];
    count_t slot_cnt [SLOTS];

    for (genvar g = 0; g < SLOTS; g++) begin : g_slot
        assign slot_fp[g]  = bucket[g*SLOT_LEN + SLOT_FP_LSB +: FP_LEN];
        assign slot_cnt[g] = bucket[g*SLOT_LEN +: COUNT_LEN];
    end

    always_comb begin
        hit       = 1'b0;
        hit_count = '0;
        has_empty = 1'b0;
        bumped    = bucket;
        placed    = bucket;
        for (int i = 0; i < SLOTS; i++) begin
            // first live slot holding the fingerprint
            if (!hit && slot_cnt[i] != '0 && slot_fp[i] == fp) begin
                hit       = 1'b1;
                hit_count = slot_cnt[i];
                bumped[i*SLOT_LEN +: COUNT_LEN] = slot_cnt[i] + count_t'(1);
            end
            // lowest empty slot gets the new key
            if (!has_empty && slot_cnt[i] == '0) begin
                has_empty = 1'b1;
                placed[i*SLOT_LEN +: SLOT_LEN] = {fp, count_t'(1)};
            end
        end
    end

endmodule

// ==== source/bucket_ram.sv ====
/*
 * bucket memory, one write and one read port
 * zero at power-up, read data one cycle after the read
 */
`timescale 1ns/100ps

module bucket_ram import cuckoo_pkg::*; #(
    parameter int TABLE_ADDR_LEN = 8
) (
    input  logic                      clk,
    input  logic                      we,
    input  logic [TABLE_ADDR_LEN-1:0] wr_addr,
    input  bucket_t                   wr_data,
    input  logic                      re,
    input  logic [TABLE_ADDR_LEN-1:0] rd_addr,
    output bucket_t                   rd_data
);

    bucket_t mem [2**TABLE_ADDR_LEN] = '{default: '0};  // count 0 = empty slot

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
        if (re) begin
            rd_data <= mem[rd_addr];
        end
    end

    // the admission lock keeps in-flight commands on distinct buckets
    a_no_rw_collision: assert property (@(posedge clk)
        !(we && re && wr_addr == rd_addr));

endmodule

// ==== source/cmd_admit.sv ====
/*
 * command admission
 * address lock over the commands in flight, primary table read issue
 */
`timescale 1ns/100ps

module cmd_admit import cuckoo_pkg::*; #(
    parameter int TABLE_ADDR_LEN = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cmd_valid,
    input  cmd_t                      cmd,
    output logic                      cmd_ready,
    output logic                      rd_en,
    output logic [TABLE_ADDR_LEN-1:0] rd_addr,
    stage_if.src                      out
);

    localparam int LOCK_DEPTH = PIPE_DEPTH - 1;  // stages still able to write

    typedef logic [TABLE_ADDR_LEN-1:0] addr_t;

    h1_t                   in_h1;
    h1_t                   in_alt_h1;
    addr_t                 in_pri;
    addr_t                 in_alt;
    logic                  accept;
    logic                  conflict;
    logic [LOCK_DEPTH-1:0] hist_valid;
    addr_t                 hist_pri [LOCK_DEPTH];
    addr_t                 hist_alt [LOCK_DEPTH];
    logic                  issued;
    cmd_t                  issued_cmd;
    addr_t                 issued_addr;

    assign in_h1     = cmd_h1(cmd);
    assign in_alt_h1 = cmd_alt_h1(cmd);
    assign in_pri    = in_h1[TABLE_ADDR_LEN-1:0];
    assign in_alt    = in_alt_h1[TABLE_ADDR_LEN-1:0];

    // any address of the new command against any address in flight
    always_comb begin
        conflict = 1'b0;
        for (int i = 0; i < LOCK_DEPTH; i++) begin
            if (hist_valid[i] && (hist_pri[i] == in_pri || hist_pri[i] == in_alt ||
                                  hist_alt[i] == in_pri || hist_alt[i] == in_alt)) begin
                conflict = 1'b1;
            end
        end
    end

    assign cmd_ready = !conflict;
    assign accept    = cmd_valid && cmd_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist_valid <= '0;
            issued     <= 1'b0;
        end else begin
            hist_valid <= {hist_valid[LOCK_DEPTH-2:0], accept};
            issued     <= accept;
        end
    end

    always_ff @(posedge clk) begin
        hist_pri[0] <= in_pri;
        hist_alt[0] <= in_alt;
        for (int i = 1; i < LOCK_DEPTH; i++) begin
            hist_pri[i] <= hist_pri[i-1];
            hist_alt[i] <= hist_alt[i-1];
        end
        issued_cmd  <= cmd;
        issued_addr <= in_pri;
    end

    assign rd_en        = issued;   // table samples one edge after acceptance
    assign rd_addr      = issued_addr;
    assign out.valid    = issued;
    assign out.cmd      = issued_cmd;
    assign out.resolved = 1'b0;
    assign out.success  = 1'b0;
    assign out.count    = '0;

    // newest accepted command shares no bucket with one still locked
    for (genvar g = 1; g < LOCK_DEPTH; g++) begin : g_lock_chk
        a_accept_ready: assert property (@(posedge clk) disable iff (!rst_n)
            hist_valid[0] && hist_valid[g] |->
                hist_pri[g] != hist_pri[0] && hist_pri[g] != hist_alt[0] &&
                hist_alt[g] != hist_pri[0] && hist_alt[g] != hist_alt[0]);
    end

    a_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
        issued |-> cmd_op(issued_cmd) inside {op_insert, op_query});

endmodule

// ==== source/cuckoo_counter_top.sv ====
/*
 * two-table cuckoo counting hash table
 * admission with address lock, primary and alternate bucket stages
 */
`timescale 1ns/100ps

module cuckoo_counter_top import cuckoo_pkg::*; #(
    parameter int TABLE_ADDR_LEN = 8
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   cmd_valid,
    input  cmd_t   cmd,
    output logic   cmd_ready,
    output logic   valid_out,
    output cmd_t   cmd_out,
    output logic   success_out,
    output count_t counter_size
);

    // primary table ports
    logic                      pri_we;
    logic [TABLE_ADDR_LEN-1:0] pri_wr_addr;
    bucket_t                   pri_wr_data;
    logic                      pri_re;
    logic [TABLE_ADDR_LEN-1:0] pri_rd_addr;
    bucket_t                   pri_rd_data;

    // alternate table ports
    logic                      alt_we;
    logic [TABLE_ADDR_LEN-1:0] alt_wr_addr;
    bucket_t                   alt_wr_data;
    logic                      alt_re;
    logic [TABLE_ADDR_LEN-1:0] alt_rd_addr;
    bucket_t                   alt_rd_data;

    stage_if adm2pri ();
    stage_if pri2alt ();

    cmd_admit #(.TABLE_ADDR_LEN(TABLE_ADDR_LEN)) u_admit (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rd_en     (pri_re),
        .rd_addr   (pri_rd_addr),
        .out       (adm2pri.src)
    );

    bucket_ram #(.TABLE_ADDR_LEN(TABLE_ADDR_LEN)) primary_table (
        .clk     (clk),
        .we      (pri_we),
        .wr_addr (pri_wr_addr),
        .wr_data (pri_wr_data),
        .re      (pri_re),
        .rd_addr (pri_rd_addr),
        .rd_data (pri_rd_data)
    );

    primary_stage #(.TABLE_ADDR_LEN(TABLE_ADDR_LEN)) u_primary (
        .clk      (clk),
        .rst_n    (rst_n),
        .in       (adm2pri.dst),
        .rd_data  (pri_rd_data),
        .we       (pri_we),
        .wr_addr  (pri_wr_addr),
        .wr_data  (pri_wr_data),
        .alt_re   (alt_re),
        .alt_addr (alt_rd_addr),
        .out      (pri2alt.src)
    );

    bucket_ram #(.TABLE_ADDR_LEN(TABLE_ADDR_LEN)) alternate_table (
        .clk     (clk),
        .we      (alt_we),
        .wr_addr (alt_wr_addr),
        .wr_data (alt_wr_data),
        .re      (alt_re),
        .rd_addr (alt_rd_addr),
        .rd_data (alt_rd_data)
    );

    alternate_stage #(.TABLE_ADDR_LEN(TABLE_ADDR_LEN)) u_alternate (
        .clk          (clk),
        .rst_n        (rst_n),
        .in           (pri2alt.dst),
        .rd_data      (alt_rd_data),
        .we           (alt_we),
        .wr_addr      (alt_wr_addr),
        .wr_data      (alt_wr_data),
        .valid_out    (valid_out),
        .cmd_out      (cmd_out),
        .success_out  (success_out),
        .counter_size (counter_size)
    );

endmodule

// ==== source/cuckoo_pkg.sv ====
/*
 * cuckoo counting table shared definitions
 * command layout, slot packing within a bucket and pipeline latency
 */
package cuckoo_pkg;

    localparam int OP_LEN     = 2;
    localparam int H1_LEN     = 20;
    localparam int FP_LEN     = 8;
    localparam int CMD_LEN    = OP_LEN + H1_LEN + FP_LEN;   // 30
    localparam int COUNT_LEN  = 24;

    // slot = {fp, count}, slot 0 in the low bits of the bucket
    localparam int SLOT_LEN    = FP_LEN + COUNT_LEN;
    localparam int SLOT_FP_LSB = COUNT_LEN;
    localparam int SLOTS       = 2;
    localparam int BUCKET_LEN  = SLOTS * SLOT_LEN;          // 64

    localparam int PIPE_DEPTH = 4;  // acceptance to result, in cycles

    typedef logic [CMD_LEN-1:0]    cmd_t;
    typedef logic [H1_LEN-1:0]     h1_t;
    typedef logic [FP_LEN-1:0]     fp_t;
    typedef logic [COUNT_LEN-1:0]  count_t;
    typedef logic [BUCKET_LEN-1:0] bucket_t;

    typedef enum logic [OP_LEN-1:0] {
        op_insert = 2'd0,
        op_query  = 2'd1
    } op_e;

    function automatic op_e cmd_op(cmd_t c);
        return op_e'(c[CMD_LEN-1 -: OP_LEN]);
    endfunction

    function automatic h1_t cmd_h1(cmd_t c);
        return c[FP_LEN +: H1_LEN];
    endfunction

    function automatic fp_t cmd_fp(cmd_t c);
        return c[FP_LEN-1:0];
    endfunction

    // alternate bucket, only the low FP_LEN bits move
    function automatic h1_t cmd_alt_h1(cmd_t c);
        return cmd_h1(c) ^ h1_t'(cmd_fp(c));
    endfunction

endpackage

// ==== source/primary_stage.sv ====
/*
 * primary bucket stage
 * resolves hits and free-slot inserts, otherwise reads the alternate table
 */
`timescale 1ns/100ps

module primary_stage import cuckoo_pkg::*; #(
    parameter int TABLE_ADDR_LEN = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    stage_if.dst                      in,
    input  bucket_t                   rd_data,
    output logic                      we,
    output logic [TABLE_ADDR_LEN-1:0] wr_addr,
    output bucket_t                   wr_data,
    output logic                      alt_re,
    output logic [TABLE_ADDR_LEN-1:0] alt_addr,
    stage_if.src                      out
);

    logic    p_valid;
    cmd_t    p_cmd;
    h1_t     p_h1;
    h1_t     p_alt_h1;
    fp_t     p_fp;
    logic    is_insert;
    logic    resolve;
    logic    hit;
    count_t  hit_count;
    logic    has_empty;
    bucket_t bumped;
    bucket_t placed;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            p_valid <= 1'b0;
        end else begin
            p_valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        p_cmd <= in.cmd;  // lines up with the table read
    end

    assign p_h1     = cmd_h1(p_cmd);
    assign p_alt_h1 = cmd_alt_h1(p_cmd);
    assign p_fp     = cmd_fp(p_cmd);

    bucket_probe u_probe (
        .bucket    (rd_data),
        .fp        (p_fp),
        .hit       (hit),
        .hit_count (hit_count),
        .has_empty (has_empty),
        .bumped    (bumped),
        .placed    (placed)
    );

    assign is_insert = (cmd_op(p_cmd) == op_insert);
    assign resolve   = hit || (is_insert && has_empty);

    assign we       = p_valid && is_insert && (hit || has_empty);
    assign wr_addr  = p_h1[TABLE_ADDR_LEN-1:0];
    assign wr_data  = hit ? bumped : placed;  // match beats a free slot
    assign alt_re   = p_valid && !resolve;
    assign alt_addr = p_alt_h1[TABLE_ADDR_LEN-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            out.valid <= p_valid;
        end
    end

    always_ff @(posedge clk) begin
        out.cmd      <= p_cmd;
        out.resolved <= resolve;
        out.success  <= resolve;
        if (hit) begin
            out.count <= is_insert ? hit_count + count_t'(1) : hit_count;
        end else begin
            out.count <= resolve ? count_t'(1) : '0;  // fresh insert starts at 1
        end
    end

endmodule

// ==== source/stage_if.sv ====
/*
 * pipeline stage link
 * one command per valid strobe plus the result found so far
 */
`timescale 1ns/100ps

interface stage_if import cuckoo_pkg::*; ();

    logic   valid;     // one-cycle strobe
    cmd_t   cmd;
    logic   resolved;  // result already final
    logic   success;
    count_t count;

    modport src (
        output valid,
        output cmd,
        output resolved,
        output success,
        output count
    );

    modport dst (
        input valid,
        input cmd,
        input resolved,
        input success,
        input count
    );

endinterface

// ==== test/tb_checks.svh ====
/*
 * result, latency and lock checks for the cuckoo table testbench
 */

int err_result  = 0;
int err_latency = 0;
int err_order   = 0;
int err_ready   = 0;

// result against the head of the expected queue
a_result: assert property (@(posedge clk) disable iff (!rst_n)
    valid_out && head_valid |-> cmd_out == head_cmd && success_out == head_success &&
                                counter_size == head_count)
else begin
    err_result++;
    $display("error %0t: cmd %h gave success %0b count %0d, expected cmd %h %0b %0d",
             $time, $sampled(cmd_out), $sampled(success_out), $sampled(counter_size),
             $sampled(head_cmd), $sampled(head_success), $sampled(head_count));
end

a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    valid_out && head_valid |-> cycle == head_acc + PIPE_DEPTH)
else begin
    err_latency++;
    $display("error %0t: result at cycle %0d, accepted at cycle %0d", $time,
             $sampled(cycle), $sampled(head_acc));
end

// no result without a pending command
a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
    valid_out |-> head_valid)
else begin
    err_order++;
    $display("error %0t: result cmd %h with no command pending", $time, $sampled(cmd_out));
end

a_not_lost: assert property (@(posedge clk) disable iff (!rst_n)
    head_valid && cycle == head_acc + PIPE_DEPTH |-> valid_out)
else begin
    err_order++;
    $display("error %0t: no result for cmd %h when due", $time, $sampled(head_cmd));
end

a_ready: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_ready == exp_ready)
else begin
    err_ready++;
    $display("error %0t: cmd_ready %0b for cmd %h, expected %0b", $time,
             $sampled(cmd_ready), $sampled(cmd), $sampled(exp_ready));
end

a_ready_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> cmd_ready)
else begin
    err_ready++;
    $display("error %0t: cmd_ready low right after reset", $time);
end

// ==== test/tb_cuckoo.sv ====
/*
 * testbench for the cuckoo counting table
 * directed and random commands against a reference model of both tables
 */
`timescale 1ns/100ps

module tb_cuckoo;
    import cuckoo_pkg::*;

    localparam int TABLE_ADDR_LEN = 8;
    localparam int LOCK_LEN       = 3;                // accepted commands held in the lock
    localparam int TIMEOUT_CYCLES = 550 * 6 + 200;

    typedef struct {
        cmd_t   cmd;
        logic   success;
        count_t count;
        int     acc;                                  // cycle count after the accepting edge
    } expect_t;

    logic   clk;
    logic   rst_n;
    logic   cmd_valid;
    cmd_t   cmd;
    logic   cmd_ready;
    logic   valid_out;
    cmd_t   cmd_out;
    logic   success_out;
    count_t counter_size;
    logic   accepted;
    logic   exp_ready;

    bucket_t       pri_tab [int];
    bucket_t       alt_tab [int];
    expect_t       exp_q [$];
    logic          head_valid = 1'b0;
    cmd_t          head_cmd;
    logic          head_success;
    count_t        head_count;
    int            head_acc;
    int            cycle = 0;
    logic [LOCK_LEN-1:0] lock_valid;
    int            lock_pri [LOCK_LEN];
    int            lock_alt [LOCK_LEN];
    integer        seed = 38;
    h1_t           full_h1 [3] = '{20'h00040, 20'h00043, 20'h00047};

    cuckoo_counter_top #(.TABLE_ADDR_LEN(TABLE_ADDR_LEN)) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .cmd_ready    (cmd_ready),
        .valid_out    (valid_out),
        .cmd_out      (cmd_out),
        .success_out  (success_out),
        .counter_size (counter_size)
    );

    function automatic cmd_t make_cmd(op_e op, h1_t h1, fp_t fp);
        return {op, h1, fp};
    endfunction

    function automatic int pri_addr(cmd_t c);
        h1_t h1;
        h1 = c[FP_LEN +: H1_LEN];
        return int'(h1[TABLE_ADDR_LEN-1:0]);
    endfunction

    // fingerprint zero-extended into the h1 width
    function automatic int alt_addr(cmd_t c);
        h1_t h1;
        h1 = c[FP_LEN +: H1_LEN] ^ h1_t'(c[FP_LEN-1:0]);
        return int'(h1[TABLE_ADDR_LEN-1:0]);
    endfunction

    function automatic count_t slot_count(bucket_t b, int i);
        return b[i*SLOT_LEN +: COUNT_LEN];
    endfunction

    function automatic int match_slot(bucket_t b, fp_t fp);
        for (int i = 0; i < SLOTS; i++) begin
            if (slot_count(b, i) != '0 && b[i*SLOT_LEN + COUNT_LEN +: FP_LEN] == fp) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int free_slot(bucket_t b);
        for (int i = 0; i < SLOTS; i++) begin
            if (slot_count(b, i) == '0) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic bucket_t set_slot(bucket_t b, int i, fp_t fp, count_t n);
        bucket_t r;
        r = b;
        r[i*SLOT_LEN +: SLOT_LEN] = {fp, n};
        return r;
    endfunction

    function automatic h1_t pick_h1(int i);
        return h1_t'(20'h05000 + i * 20'h11);
    endfunction

    function automatic fp_t pick_fp(int i);
        case (i)
            0: return 8'h00;
            1: return 8'h01;
            2: return 8'h11;
            default: return 8'h80;
        endcase
    endfunction

    // reference model, primary table first, then the alternate
    task automatic apply_model(input cmd_t c, input int acc);
        logic    ins;
        fp_t     fp;
        int      pa;
        int      aa;
        bucket_t pb;
        bucket_t ab;
        int      pri_hit;
        int      pri_free;
        int      alt_hit;
        int      alt_free;
        expect_t e;
        ins      = (c[CMD_LEN-1 -: OP_LEN] == op_insert);
        fp       = c[FP_LEN-1:0];
        pa       = pri_addr(c);
        aa       = alt_addr(c);
        pb       = pri_tab.exists(pa) ? pri_tab[pa] : '0;
        ab       = alt_tab.exists(aa) ? alt_tab[aa] : '0;
        pri_hit  = match_slot(pb, fp);
        pri_free = free_slot(pb);
        alt_hit  = match_slot(ab, fp);
        alt_free = free_slot(ab);
        e.cmd     = c;
        e.acc     = acc;
        e.success = 1'b1;
        if (pri_hit >= 0) begin
            e.count = slot_count(pb, pri_hit) + (ins ? count_t'(1) : count_t'(0));
            if (ins) begin
                pri_tab[pa] = set_slot(pb, pri_hit, fp, e.count);
            end
        end else if (ins && pri_free >= 0) begin
            e.count     = count_t'(1);
            pri_tab[pa] = set_slot(pb, pri_free, fp, e.count);
        end else if (alt_hit >= 0) begin
            e.count = slot_count(ab, alt_hit) + (ins ? count_t'(1) : count_t'(0));
            if (ins) begin
                alt_tab[aa] = set_slot(ab, alt_hit, fp, e.count);
            end
        end else if (ins && alt_free >= 0) begin
            e.count     = count_t'(1);
            alt_tab[aa] = set_slot(ab, alt_free, fp, e.count);
        end else begin
            e.success = 1'b0;    // both full or key absent
            e.count   = '0;
        end
        exp_q.push_back(e);
    endtask

    // hold the command until the lock lets it in
    task automatic issue(input cmd_t c);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(posedge clk);
        while (!cmd_ready) begin
            @(posedge clk);
        end
        cmd_valid <= 1'b0;
    endtask

    `include "tb_checks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    assign accepted = cmd_valid && cmd_ready;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // lock history of the last accepted address pairs
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lock_valid <= '0;
        end else begin
            lock_valid  <= {lock_valid[LOCK_LEN-2:0], accepted};
            lock_pri[0] <= pri_addr(cmd);
            lock_alt[0] <= alt_addr(cmd);
            for (int i = 1; i < LOCK_LEN; i++) begin
                lock_pri[i] <= lock_pri[i-1];
                lock_alt[i] <= lock_alt[i-1];
            end
        end
    end

    always_comb begin
        int cp;
        int ca;
        cp        = pri_addr(cmd);
        ca        = alt_addr(cmd);
        exp_ready = 1'b1;
        for (int i = 0; i < LOCK_LEN; i++) begin
            if (lock_valid[i] && (lock_pri[i] == cp || lock_pri[i] == ca ||
                                  lock_alt[i] == cp || lock_alt[i] == ca)) begin
                exp_ready = 1'b0;
            end
        end
    end

    // retire on valid_out, record on acceptance, expose the queue head
    always @(posedge clk) begin
        if (rst_n) begin
            if (valid_out && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
            end
            if (accepted) begin
                apply_model(cmd, cycle + 1);
            end
            if (exp_q.size() > 0) begin
                head_valid   <= 1'b1;
                head_cmd     <= exp_q[0].cmd;
                head_success <= exp_q[0].success;
                head_count   <= exp_q[0].count;
                head_acc     <= exp_q[0].acc;
            end else begin
                head_valid <= 1'b0;
            end
        end
    end

    initial begin
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        $display("timeout: run not finished after %0d cycles, %0d results outstanding",
                 TIMEOUT_CYCLES, exp_q.size());
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        op_e         rop;
        cmd_valid = 1'b0;
        cmd       = '0;
        rst_n     = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        for (int i = 0; i < 4; i++) begin
            issue(make_cmd(op_insert, 20'h00010, 8'h21));  // counts 1 to 4
        end
        issue(make_cmd(op_query, 20'h00010, 8'h21));
        issue(make_cmd(op_query, 20'h00020, 8'h33));       // never inserted

        // disjoint buckets, no lock stalls expected
        for (int i = 0; i < 4; i++) begin
            issue(make_cmd(op_insert, 20'h00080 + 20'(i * 16), 8'h00));
        end

        // fill three primary buckets, then overflow into alternate 0x43
        foreach (full_h1[i]) begin
            issue(make_cmd(op_insert, full_h1[i], 8'h01));
            issue(make_cmd(op_insert, full_h1[i], 8'h02));
        end
        issue(make_cmd(op_insert, 20'h00040, 8'h03));
        issue(make_cmd(op_insert, 20'h00043, 8'h00));
        issue(make_cmd(op_insert, 20'h00047, 8'h04));      // both buckets full
        issue(make_cmd(op_query, 20'h00040, 8'h03));
        issue(make_cmd(op_query, 20'h00043, 8'h00));
        issue(make_cmd(op_query, 20'h00047, 8'h04));
        issue(make_cmd(op_query, 20'h00047, 8'h01));
        issue(make_cmd(op_insert, 20'h00040, 8'h03));      // hit in the alternate

        for (int n = 0; n < 500; n++) begin
            r   = $random(seed);
            rop = (r[1:0] == 2'd0) ? op_query : op_insert;
            issue(make_cmd(rop, pick_h1(int'(r[5:2])), pick_fp(int'(r[7:6]))));
            if (r[10:8] == 3'd0) begin
                @(posedge clk);
            end
        end

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        $display("summary: result errors %0d, latency errors %0d, order errors %0d, ready errors %0d",
                 err_result, err_latency, err_order, err_ready);
        if (err_result + err_latency + err_order + err_ready == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
